// File: Makefile
# Verilator build and run of the crossbar testbench

VERILATOR ?= verilator
TOP       ?= tb_system_xbar
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_LINE ?= Test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_LINE)"

clean:
	rm -rf $(BUILD_DIR)

// File: project.f
+incdir+source
source/obi_pkg.sv
source/obi_bus_if.sv
source/obi_addr_decoder.sv
source/obi_sram_bank.sv
source/obi_xbar.sv
source/system_xbar_top.sv
verification/xbar_checker.sv
verification/tb_system_xbar.sv

// File: source/obi_addr_decoder.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address decoder for one manager port
// Picks SRAM0, SRAM1 or the error responder from the region nibble
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "xbar_macros.svh"

module obi_addr_decoder (
  input  obi_pkg::obi_addr_u  addr_i,
  output obi_pkg::slave_sel_e sel_o
);

  always_comb begin
    case (addr_i.fields.region)
      `XBAR_REGION_SRAM0: begin
        sel_o = obi_pkg::SEL_SRAM0;
      end
      `XBAR_REGION_SRAM1: begin
        sel_o = obi_pkg::SEL_SRAM1;
      end
      // Anything else is unmapped
      default: begin
        sel_o = obi_pkg::SEL_ERR;
      end
    endcase
  end

  // Encoding 2'd3 must never reach the crossbar
  always_comb begin
    a_sel_legal: assert (sel_o inside {obi_pkg::SEL_SRAM0, obi_pkg::SEL_SRAM1,
                                       obi_pkg::SEL_ERR})
      else $error("decoder produced an illegal target select");
  end

endmodule

// File: source/obi_bus_if.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// OBI request/response bundle with manager and subordinate views
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

interface obi_bus_if;

  // Request channel
  logic               req;
  logic               gnt;
  obi_pkg::obi_addr_u addr;
  logic               we;
  logic [3:0]         be;
  logic [31:0]        wdata;

  // Response channel, rvalid is a one-cycle pulse
  logic               rvalid;
  logic [31:0]        rdata;
  logic               err;

  modport manager (
    output req, addr, we, be, wdata,
    input  gnt, rvalid, rdata, err
  );

  modport subordinate (
    input  req, addr, we, be, wdata,
    output gnt, rvalid, rdata, err
  );

endinterface

// File: source/obi_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// OBI crossbar types
// Target select and the two views of a bus address
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package obi_pkg;

  // Crossbar target of one request
  typedef enum logic [1:0] {
    SEL_SRAM0 = 2'd0,
    SEL_SRAM1 = 2'd1,
    SEL_ERR   = 2'd2
  } slave_sel_e;

  // Decoded view of a byte address
  typedef struct packed {
    logic [3:0]  region;
    logic [25:0] word_off;
    logic [1:0]  lane;
  } obi_addr_fields_t;

  // Raw byte address, or region / word / lane
  typedef union packed {
    logic [31:0]      raw;
    obi_addr_fields_t fields;
  } obi_addr_u;

endpackage

// File: source/obi_sram_bank.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single-port word SRAM on an OBI subordinate port
// Byte-lane writes, read data one cycle after acceptance
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "xbar_macros.svh"

module obi_sram_bank #(
  parameter int WORDS = `XBAR_SRAM_WORDS
) (
  input  logic           clk_i,
  input  logic           rst_n_i,
  obi_bus_if.subordinate bus
);

  localparam int AW = (WORDS > 1) ? $clog2(WORDS) : 1;

  logic [31:0]   mem [WORDS];
  logic [AW-1:0] idx;
  logic          accept;
  logic          rvalid_q;
  logic [31:0]   rdata_q;

  // Never stalls
  assign bus.gnt = bus.req;
  assign accept  = bus.req & bus.gnt;
  assign idx     = bus.addr.fields.word_off[AW-1:0];

  always_ff @(posedge clk_i) begin
    if (accept) begin
      if (bus.we) begin
        for (int b = 0; b < 4; b++) begin
          if (bus.be[b]) begin
            mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem[idx];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= accept;
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = 1'b0;

  // Every response belongs to the request accepted one edge earlier
  a_rvalid_follows_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bus.rvalid |-> $past(accept));

endmodule

// File: source/obi_xbar.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-manager OBI crossbar with per-bank round-robin arbitration
// Unmapped requests are answered by an internal error responder
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "xbar_macros.svh"

module obi_xbar (
  input  logic                clk_i,
  input  logic                rst_n_i,
  obi_bus_if.subordinate      m0,
  obi_bus_if.subordinate      m1,
  input  obi_pkg::slave_sel_e m0_sel_i,
  input  obi_pkg::slave_sel_e m1_sel_i,
  obi_bus_if.manager          s0,
  obi_bus_if.manager          s1
);

  // Manager side, index is the manager number
  logic [1:0]          m_req;
  obi_pkg::slave_sel_e m_sel [2];
  logic [1:0]          m_gnt;
  logic [1:0]          m_rvalid;
  logic [1:0]          m_err;
  logic [31:0]         m_rdata [2];

  // Bank side, index is the bank number
  logic [1:0]          hit [2];
  logic [1:0]          b_req;
  logic [1:0]          b_win;
  logic [1:0]          b_gnt;
  logic [1:0]          b_rvalid;
  logic [1:0]          b_err;
  logic [31:0]         b_rdata [2];

  // rr_q[t] high means bank t favours m1 on the next tie
  logic [1:0]          rr_q;
  logic [1:0]          pend_q;
  logic [1:0]          err_vld_q;
  obi_pkg::slave_sel_e tgt_q [2];

  // No new request while a response is still on its way
  assign m_req[0] = m0.req & ~pend_q[0];
  assign m_req[1] = m1.req & ~pend_q[1];
  assign m_sel[0] = m0_sel_i;
  assign m_sel[1] = m1_sel_i;

  always_comb begin
    for (int t = 0; t < 2; t++) begin
      for (int k = 0; k < 2; k++) begin
        hit[t][k] = m_req[k] && (m_sel[k] == obi_pkg::slave_sel_e'(t));
      end
      b_req[t] = |hit[t];
      if (hit[t] == 2'b11) begin
        b_win[t] = rr_q[t];
      end else begin
        b_win[t] = hit[t][1];
      end
    end
  end

  // Error target takes every request, banks only their winner
  always_comb begin
    for (int k = 0; k < 2; k++) begin
      m_gnt[k] = m_req[k] && (m_sel[k] == obi_pkg::SEL_ERR);
      for (int t = 0; t < 2; t++) begin
        if (hit[t][k] && (b_win[t] == 1'(k)) && b_gnt[t]) begin
          m_gnt[k] = 1'b1;
        end
      end
    end
  end

  // Winner's request fields to each bank
  assign s0.req   = b_req[0];
  assign s0.addr  = b_win[0] ? m1.addr  : m0.addr;
  assign s0.we    = b_win[0] ? m1.we    : m0.we;
  assign s0.be    = b_win[0] ? m1.be    : m0.be;
  assign s0.wdata = b_win[0] ? m1.wdata : m0.wdata;

  assign s1.req   = b_req[1];
  assign s1.addr  = b_win[1] ? m1.addr  : m0.addr;
  assign s1.we    = b_win[1] ? m1.we    : m0.we;
  assign s1.be    = b_win[1] ? m1.be    : m0.be;
  assign s1.wdata = b_win[1] ? m1.wdata : m0.wdata;

  assign b_gnt      = {s1.gnt, s0.gnt};
  assign b_rvalid   = {s1.rvalid, s0.rvalid};
  assign b_err      = {s1.err, s0.err};
  assign b_rdata[0] = s0.rdata;
  assign b_rdata[1] = s1.rdata;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_q      <= '0;
      pend_q    <= '0;
      err_vld_q <= '0;
    end else begin
      pend_q <= m_gnt;
      for (int k = 0; k < 2; k++) begin
        err_vld_q[k] <= m_gnt[k] && (m_sel[k] == obi_pkg::SEL_ERR);
      end
      // Pointer moves away from whoever the bank just served
      for (int t = 0; t < 2; t++) begin
        if (b_req[t] && b_gnt[t]) begin
          rr_q[t] <= ~b_win[t];
        end
      end
    end
  end

  // Target of the accepted request, used to steer the response
  always_ff @(posedge clk_i) begin
    for (int k = 0; k < 2; k++) begin
      if (m_gnt[k]) begin
        tgt_q[k] <= m_sel[k];
      end
    end
  end

  always_comb begin
    for (int k = 0; k < 2; k++) begin
      m_rvalid[k] = err_vld_q[k];
      m_err[k]    = err_vld_q[k];
      m_rdata[k]  = `XBAR_ERR_RDATA;
      if (pend_q[k] && (tgt_q[k] == obi_pkg::SEL_SRAM0)) begin
        m_rvalid[k] = b_rvalid[0];
        m_err[k]    = b_err[0];
        m_rdata[k]  = b_rdata[0];
      end else if (pend_q[k] && (tgt_q[k] == obi_pkg::SEL_SRAM1)) begin
        m_rvalid[k] = b_rvalid[1];
        m_err[k]    = b_err[1];
        m_rdata[k]  = b_rdata[1];
      end
    end
  end

  assign m0.gnt    = m_gnt[0];
  assign m0.rvalid = m_rvalid[0];
  assign m0.rdata  = m_rdata[0];
  assign m0.err    = m_err[0];
  assign m1.gnt    = m_gnt[1];
  assign m1.rvalid = m_rvalid[1];
  assign m1.rdata  = m_rdata[1];
  assign m1.err    = m_err[1];

  // Response on the next edge and no second grant in between
  a_m0_resp_next: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    m0.gnt |=> m0.rvalid && !m0.gnt);
  a_m1_resp_next: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    m1.gnt |=> m1.rvalid && !m1.gnt);

  // A bank serves at most one manager per cycle
  a_bank_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(m0.gnt && m1.gnt && (m0_sel_i == m1_sel_i) && (m0_sel_i != obi_pkg::SEL_ERR)));

endmodule

// File: source/system_xbar_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// System bus top: two OBI managers sharing two SRAM banks
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module system_xbar_top (
  input  logic        clk_i,
  input  logic        rst_n_i,

  input  logic        m0_req_i,
  input  logic [31:0] m0_addr_i,
  input  logic        m0_we_i,
  input  logic [3:0]  m0_be_i,
  input  logic [31:0] m0_wdata_i,
  output logic        m0_gnt_o,
  output logic        m0_rvalid_o,
  output logic [31:0] m0_rdata_o,
  output logic        m0_err_o,

  input  logic        m1_req_i,
  input  logic [31:0] m1_addr_i,
  input  logic        m1_we_i,
  input  logic [3:0]  m1_be_i,
  input  logic [31:0] m1_wdata_i,
  output logic        m1_gnt_o,
  output logic        m1_rvalid_o,
  output logic [31:0] m1_rdata_o,
  output logic        m1_err_o
);

  obi_pkg::slave_sel_e m0_sel;
  obi_pkg::slave_sel_e m1_sel;

  obi_bus_if m0_bus ();
  obi_bus_if m1_bus ();
  obi_bus_if s0_bus ();
  obi_bus_if s1_bus ();

  // Manager 0 pins onto its bus
  assign m0_bus.req      = m0_req_i;
  assign m0_bus.addr.raw = m0_addr_i;
  assign m0_bus.we       = m0_we_i;
  assign m0_bus.be       = m0_be_i;
  assign m0_bus.wdata    = m0_wdata_i;
  assign m0_gnt_o        = m0_bus.gnt;
  assign m0_rvalid_o     = m0_bus.rvalid;
  assign m0_rdata_o      = m0_bus.rdata;
  assign m0_err_o        = m0_bus.err;

  // Manager 1 pins onto its bus
  assign m1_bus.req      = m1_req_i;
  assign m1_bus.addr.raw = m1_addr_i;
  assign m1_bus.we       = m1_we_i;
  assign m1_bus.be       = m1_be_i;
  assign m1_bus.wdata    = m1_wdata_i;
  assign m1_gnt_o        = m1_bus.gnt;
  assign m1_rvalid_o     = m1_bus.rvalid;
  assign m1_rdata_o      = m1_bus.rdata;
  assign m1_err_o        = m1_bus.err;

  obi_addr_decoder obi_addr_decoder_m0_inst (
    .addr_i (m0_bus.addr),
    .sel_o  (m0_sel)
  );

  obi_addr_decoder obi_addr_decoder_m1_inst (
    .addr_i (m1_bus.addr),
    .sel_o  (m1_sel)
  );

  obi_xbar obi_xbar_inst (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .m0       (m0_bus.subordinate),
    .m1       (m1_bus.subordinate),
    .m0_sel_i (m0_sel),
    .m1_sel_i (m1_sel),
    .s0       (s0_bus.manager),
    .s1       (s1_bus.manager)
  );

  obi_sram_bank obi_sram_bank0_inst (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .bus     (s0_bus.subordinate)
  );

  obi_sram_bank obi_sram_bank1_inst (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .bus     (s1_bus.subordinate)
  );

endmodule

// File: source/xbar_macros.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Crossbar address map and bank sizing
// Region codes sit in the top address nibble
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef XBAR_MACROS_SVH
`define XBAR_MACROS_SVH

// Region code of bank 0, address bits 31:28
`define XBAR_REGION_SRAM0 4'h0

// Region code of bank 1
`define XBAR_REGION_SRAM1 4'h1

// Bank depth in 32-bit words
`define XBAR_SRAM_WORDS 256

// Read word returned for unmapped accesses
`define XBAR_ERR_RDATA 32'hBADC_0DE5

`endif

// File: verification/tb_system_xbar.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the two-manager OBI crossbar system
// Directed and LCG-driven traffic on both managers
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "xbar_macros.svh"

module tb_system_xbar;

  localparam int WAIT_LIMIT = 16;

  logic             clk_i;
  logic             rst_n_i;
  logic [1:0]       req;
  logic [1:0]       we;
  logic [1:0][31:0] addr;
  logic [1:0][3:0]  be;
  logic [1:0][31:0] wdata;
  wire  [1:0]       gnt;
  wire  [1:0]       rvalid;
  wire  [1:0]       err;
  wire  [1:0][31:0] rdata;
  int               pass_count;
  int               fail_count;
  int               timeouts;
  int               fails_before;
  int               test_num;
  logic [31:0]      lcg_state;

  system_xbar_top system_xbar_top_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .m0_req_i    (req[0]),
    .m0_addr_i   (addr[0]),
    .m0_we_i     (we[0]),
    .m0_be_i     (be[0]),
    .m0_wdata_i  (wdata[0]),
    .m0_gnt_o    (gnt[0]),
    .m0_rvalid_o (rvalid[0]),
    .m0_rdata_o  (rdata[0]),
    .m0_err_o    (err[0]),
    .m1_req_i    (req[1]),
    .m1_addr_i   (addr[1]),
    .m1_we_i     (we[1]),
    .m1_be_i     (be[1]),
    .m1_wdata_i  (wdata[1]),
    .m1_gnt_o    (gnt[1]),
    .m1_rvalid_o (rvalid[1]),
    .m1_rdata_o  (rdata[1]),
    .m1_err_o    (err[1])
  );

  xbar_checker xbar_checker_inst (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_i        (req),
    .addr_i       (addr),
    .we_i         (we),
    .be_i         (be),
    .wdata_i      (wdata),
    .gnt_i        (gnt),
    .rvalid_i     (rvalid),
    .rdata_i      (rdata),
    .err_i        (err),
    .pass_count_o (pass_count),
    .fail_count_o (fail_count)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] make_addr(input logic [3:0] region, input int word);
    return {region, 22'd0, word[3:0], 2'b00};
  endfunction

  // Banks or an unmapped region, words 0..15, any byte lane
  function automatic logic [31:0] rand_addr();
    logic [31:0] r;
    logic [3:0]  region;
    r = lcg_next();
    if (r[17:16] == 2'd3) begin
      region = {1'b1, r[20:18]};
    end else if (r[16]) begin
      region = `XBAR_REGION_SRAM1;
    end else begin
      region = `XBAR_REGION_SRAM0;
    end
    return {region, 22'd0, r[27:24], r[29:28]};
  endfunction

  // One OBI transfer, inputs change 2 ns after the rising edge
  task automatic run_access(input int m, input logic [31:0] a, input logic w,
                            input logic [3:0] b, input logic [31:0] d);
    int n;
    @(posedge clk_i);
    #2;
    req[m]   = 1'b1;
    addr[m]  = a;
    we[m]    = w;
    be[m]    = b;
    wdata[m] = d;
    n = 0;
    @(negedge clk_i);
    while (!gnt[m] && n < WAIT_LIMIT) begin
      @(negedge clk_i);
      n++;
    end
    if (!gnt[m]) begin
      $display("%0t: m%0d timed out waiting for a grant", $time, m);
      timeouts++;
      @(posedge clk_i);
      #2;
      req[m] = 1'b0;
    end else begin
      @(posedge clk_i);
      #2;
      req[m] = 1'b0;
      n = 0;
      @(negedge clk_i);
      while (!rvalid[m] && n < WAIT_LIMIT) begin
        @(negedge clk_i);
        n++;
      end
      if (!rvalid[m]) begin
        $display("%0t: m%0d timed out waiting for a response", $time, m);
        timeouts++;
      end
    end
  endtask

  task automatic report_test(input string name);
    int now_fails;
    @(posedge clk_i);
    #2;
    now_fails = fail_count + timeouts;
    test_num++;
    $display("test %0d %s: %0d new failures", test_num, name, now_fails - fails_before);
    fails_before = now_fails;
  endtask

  initial begin
    logic [31:0] a0;
    logic [31:0] a1;
    logic [31:0] r0;
    logic [31:0] r1;
    req          = '0;
    we           = '0;
    addr         = '0;
    be           = '0;
    wdata        = '0;
    rst_n_i      = 1'b0;
    timeouts     = 0;
    fails_before = 0;
    test_num     = 0;
    lcg_state    = 32'h61d55b2c;
    repeat (8) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;

    // First tie on each bank after reset goes to m0
    r0 = lcg_next();
    fork
      run_access(0, make_addr(`XBAR_REGION_SRAM1, 7), 1'b1, 4'hF, r0);
      run_access(1, make_addr(`XBAR_REGION_SRAM1, 7), 1'b0, 4'hF, 32'h0);
    join

    // Readback by the previous tie winner keeps the ties alternating
    for (int i = 0; i < 10; i++) begin
      r0 = lcg_next();
      r1 = lcg_next();
      fork
        run_access(0, make_addr(`XBAR_REGION_SRAM0, 7), 1'b1, 4'hF, r0);
        run_access(1, make_addr(`XBAR_REGION_SRAM0, 7), 1'b1, 4'h3, r1);
      join
      run_access(i % 2, make_addr(`XBAR_REGION_SRAM0, 7), 1'b0, 4'hF, 32'h0);
    end
    report_test("bank contention");

    // Full-word fill of the test window, then read back
    for (int w = 0; w < 16; w++) begin
      run_access(0, make_addr(`XBAR_REGION_SRAM0, w), 1'b1, 4'hF, lcg_next());
      run_access(0, make_addr(`XBAR_REGION_SRAM1, w), 1'b1, 4'hF, lcg_next());
    end
    for (int w = 0; w < 16; w++) begin
      run_access(0, make_addr(`XBAR_REGION_SRAM0, w), 1'b0, 4'hF, 32'h0);
      run_access(0, make_addr(`XBAR_REGION_SRAM1, w), 1'b0, 4'hF, 32'h0);
    end
    report_test("write and read back");

    for (int i = 0; i < 16; i++) begin
      r0 = lcg_next();
      a0 = make_addr(r0[0] ? `XBAR_REGION_SRAM1 : `XBAR_REGION_SRAM0, int'(r0[27:24]));
      run_access(0, a0, 1'b1, r0[31:28], lcg_next());
      run_access(0, a0, 1'b0, 4'hF, 32'h0);
    end
    report_test("byte enables");

    for (int i = 0; i < 16; i++) begin
      fork
        run_access(0, make_addr(`XBAR_REGION_SRAM0, i), i[0], 4'hF, lcg_state ^ 32'h1);
        run_access(1, make_addr(`XBAR_REGION_SRAM1, 15 - i), i[0], 4'hF, lcg_state);
      join
    end
    report_test("parallel banks");

    fork
      run_access(0, make_addr(4'hA, 3), 1'b1, 4'hF, 32'hFFFF_FFFF);
      run_access(1, make_addr(4'hF, 3), 1'b0, 4'hF, 32'h0);
    join
    fork
      run_access(0, make_addr(4'hF, 3), 1'b0, 4'hF, 32'h0);
      run_access(1, make_addr(4'hA, 3), 1'b1, 4'h5, 32'h1234_5678);
    join
    run_access(0, make_addr(`XBAR_REGION_SRAM0, 3), 1'b0, 4'hF, 32'h0);
    run_access(1, make_addr(`XBAR_REGION_SRAM1, 3), 1'b0, 4'hF, 32'h0);
    report_test("unmapped addresses");

    for (int i = 0; i < 300; i++) begin
      a0 = rand_addr();
      a1 = rand_addr();
      r0 = lcg_next();
      r1 = lcg_next();
      fork
        run_access(0, a0, r0[31], r0[27:24], lcg_state);
        run_access(1, a1, r1[31], r1[27:24], r0 ^ r1);
      join
    end
    report_test("random traffic");

    $display("checks passed %0d, failed %0d", pass_count, fail_count + timeouts);
    if (fail_count + timeouts == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: verification/xbar_checker.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Scoreboard for the two-manager crossbar
// Predicts grants and responses from a shadow copy of both banks
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "xbar_macros.svh"

module xbar_checker (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic [1:0]       req_i,
  input  logic [1:0][31:0] addr_i,
  input  logic [1:0]       we_i,
  input  logic [1:0][3:0]  be_i,
  input  logic [1:0][31:0] wdata_i,
  input  logic [1:0]       gnt_i,
  input  logic [1:0]       rvalid_i,
  input  logic [1:0][31:0] rdata_i,
  input  logic [1:0]       err_i,
  output int               pass_count_o,
  output int               fail_count_o
);

  logic [31:0] shadow [2][`XBAR_SRAM_WORDS];
  logic [1:0]  pend;
  // rr[t] high means bank t favours m1 on the next tie
  logic [1:0]  rr;
  logic [1:0]  exp_err;
  logic [1:0]  chk_rdata;
  logic [31:0] exp_rdata [2];
  logic [31:0] exp_addr [2];

  // 0 and 1 are the banks, 2 is the error responder
  function automatic int target_of(input logic [31:0] a);
    if (a[31:28] == `XBAR_REGION_SRAM0) begin
      return 0;
    end
    if (a[31:28] == `XBAR_REGION_SRAM1) begin
      return 1;
    end
    return 2;
  endfunction

  // Reference write, enabled lanes take the new bytes
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  lanes);
    logic [31:0] w;
    w = old_word;
    for (int b = 0; b < 4; b++) begin
      if (lanes[b]) begin
        w[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return w;
  endfunction

  always @(posedge clk_i) begin
    int   tgt [2];
    int   idx;
    logic contend;
    logic exp_gnt;
    if (!rst_n_i) begin
      pend         = '0;
      rr           = '0;
      pass_count_o = 0;
      fail_count_o = 0;
    end else begin
      for (int k = 0; k < 2; k++) begin
        tgt[k] = target_of(addr_i[k]);
      end
      // Response exactly one cycle after acceptance
      for (int k = 0; k < 2; k++) begin
        if (rvalid_i[k] !== pend[k]) begin
          fail_count_o++;
          $display("[FAIL] %0t m%0d rvalid %0b, expected %0b",
                   $time, k, rvalid_i[k], pend[k]);
        end else if (pend[k]) begin
          if (err_i[k] !== exp_err[k] ||
              (chk_rdata[k] && rdata_i[k] !== exp_rdata[k])) begin
            fail_count_o++;
            $display("[FAIL] %0t m%0d addr 0x%08h: rdata 0x%08h err %0b, expected 0x%08h err %0b",
                     $time, k, exp_addr[k], rdata_i[k], err_i[k], exp_rdata[k], exp_err[k]);
          end else begin
            pass_count_o++;
          end
        end
      end
      // Ties on one bank go to the round-robin favourite
      for (int k = 0; k < 2; k++) begin
        exp_gnt = 1'b0;
        if (req_i[k] && !pend[k]) begin
          contend = req_i[1-k] && !pend[1-k] && (tgt[1-k] == tgt[k]) && (tgt[k] != 2);
          exp_gnt = 1'b1;
          if (contend) begin
            exp_gnt = (int'(rr[tgt[k]]) == k);
          end
        end
        if (gnt_i[k] !== exp_gnt) begin
          fail_count_o++;
          $display("[FAIL] %0t m%0d gnt %0b, expected %0b", $time, k, gnt_i[k], exp_gnt);
        end else if (req_i[k]) begin
          pass_count_o++;
        end
      end
      // Acceptances update the shadow banks in order
      for (int k = 0; k < 2; k++) begin
        pend[k] = req_i[k] && gnt_i[k];
        if (pend[k]) begin
          exp_addr[k]  = addr_i[k];
          exp_err[k]   = (tgt[k] == 2);
          chk_rdata[k] = (tgt[k] == 2) || !we_i[k];
          exp_rdata[k] = `XBAR_ERR_RDATA;
          if (tgt[k] != 2) begin
            idx         = int'((addr_i[k] >> 2) % `XBAR_SRAM_WORDS);
            rr[tgt[k]]  = (k == 0);
            if (we_i[k]) begin
              shadow[tgt[k]][idx] = merge_bytes(shadow[tgt[k]][idx], wdata_i[k], be_i[k]);
            end else begin
              exp_rdata[k] = shadow[tgt[k]][idx];
            end
          end
        end
      end
    end
  end

endmodule
